// File: Bender.yml
package:
  name: rtr_route_stage

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/rtr_pkg.sv
      - src/rtr_route_compute.sv
      - src/rtr_route_fifo.sv
      - src/rtr_route_filter.sv
      - src/rtr_route_stage.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/rtr_route_properties.sv
      - test/rtr_route_stage_tb.sv

// File: rtr_route_stage.f
+incdir+src
src/rtr_pkg.sv
src/rtr_route_compute.sv
src/rtr_route_fifo.sv
src/rtr_route_filter.sv
src/rtr_route_stage.sv
test/rtr_route_properties.sv
test/rtr_route_stage_tb.sv

// File: src/rtr_cfg.svh
// router sizing macros for a 4x4 mesh with one local node, values must agree with rtr_pkg widths
`ifndef RTR_CFG_SVH
`define RTR_CFG_SVH

// ----------------------------------------------------------------------
// mesh geometry
// ----------------------------------------------------------------------

// bits per mesh coordinate, 2 bits gives a 4x4 mesh
`define RTR_COORD_BITS 2

// x-minus, x-plus, y-minus, y-plus and the local port
`define RTR_NUM_PORTS 5

// minus and plus neighbor in each dimension
`define RTR_NUM_NEIGHBORS_PER_DIM 2

// local nodes attached to this router
`define RTR_NUM_NODES 1

// ----------------------------------------------------------------------
// classes and buffering
// ----------------------------------------------------------------------

// class 0 heads for the intermediate node, class 1 for the destination
`define RTR_NUM_RES_CLASSES 2
`define RTR_RES_CLASS_BITS $clog2(`RTR_NUM_RES_CLASSES)

// request and reply
`define RTR_NUM_MSG_CLASSES 2
`define RTR_MSG_CLASS_BITS $clog2(`RTR_NUM_MSG_CLASSES)

// route request buffer entries
`define RTR_FIFO_DEPTH 4

`endif

// File: src/rtr_pkg.sv
// shared route types, the port and order encodings follow rtr_cfg.svh and must not be reordered
`default_nettype none

`include "rtr_cfg.svh"

package rtr_pkg;

   // ----------------------------------------------------------------------
   // port indices
   // ----------------------------------------------------------------------

   // network ports first, dimension = index / neighbors per dim
   typedef enum logic [$clog2(`RTR_NUM_PORTS)-1:0] {
      PORT_XM    = 0,
      PORT_XP    = 1,
      PORT_YM    = 2,
      PORT_YP    = 3,
      PORT_LOCAL = 4
   } port_e;

   // ----------------------------------------------------------------------
   // dimension traversal order
   // ----------------------------------------------------------------------

   // by-class sends even message classes x first, odd ones y first
   // reserved behaves like ascending
   typedef enum logic [1:0] {
      DIM_ORDER_ASCENDING  = 2'd0,
      DIM_ORDER_DESCENDING = 2'd1,
      DIM_ORDER_BY_CLASS   = 2'd2,
      DIM_ORDER_RESERVED   = 2'd3
   } dim_order_e;

   // ----------------------------------------------------------------------
   // route request held in the fifo
   // ----------------------------------------------------------------------

   // op and orc are one-hot, bit 0 is the leftmost bit as in port 0
   typedef struct packed {
      logic [0:`RTR_NUM_PORTS-1]       op;
      logic [0:`RTR_NUM_RES_CLASSES-1] orc;
      logic [`RTR_MSG_CLASS_BITS-1:0]  msg_class;
      logic [`RTR_RES_CLASS_BITS-1:0]  res_class;
   } route_req_t;

endpackage

`default_nettype wire

// File: src/rtr_route_compute.sv
// phased DOR with line connectivity only, one head flit per cycle, router_x and router_y must fit in RTR_COORD_BITS
`default_nettype none
`timescale 1ns/100ps

`include "rtr_cfg.svh"

module rtr_route_compute #(
   parameter int unsigned router_x = 0,
   parameter int unsigned router_y = 0
) (
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic [1:0]                     mode_dim_order,
   input  logic                           head_valid,
   input  logic [`RTR_COORD_BITS-1:0]     dest_x,
   input  logic [`RTR_COORD_BITS-1:0]     dest_y,
   input  logic [`RTR_COORD_BITS-1:0]     inter_x,
   input  logic [`RTR_COORD_BITS-1:0]     inter_y,
   input  logic [`RTR_MSG_CLASS_BITS-1:0] msg_class,
   input  logic [`RTR_RES_CLASS_BITS-1:0] res_class,
   output logic                           wr_en,
   output rtr_pkg::route_req_t            wr_data
);

   localparam int unsigned port_bits = $clog2(`RTR_NUM_PORTS);

   // own position in the mesh
   localparam logic [`RTR_COORD_BITS-1:0] here_x = `RTR_COORD_BITS'(router_x);
   localparam logic [`RTR_COORD_BITS-1:0] here_y = `RTR_COORD_BITS'(router_y);

   rtr_pkg::dim_order_e              dim_order;
   logic                             at_inter;
   logic [`RTR_RES_CLASS_BITS-1:0]   out_class;
   logic [`RTR_COORD_BITS-1:0]       tgt_x;
   logic [`RTR_COORD_BITS-1:0]       tgt_y;
   logic                             x_done;
   logic                             y_done;
   logic                             x_first;
   logic [port_bits-1:0]             port_sel;
   rtr_pkg::route_req_t              req_next;

   assign dim_order = rtr_pkg::dim_order_e'(mode_dim_order);

   // ----------------------------------------------------------------------
   // phase and target selection
   // ----------------------------------------------------------------------

   // hitting the intermediate node in class 0 starts the second phase
   assign at_inter  = (inter_x == here_x) && (inter_y == here_y);
   assign out_class = ((res_class == '0) && at_inter) ? `RTR_RES_CLASS_BITS'(1) : res_class;

   // class 0 still heads for the intermediate node
   assign tgt_x  = (out_class == '0) ? inter_x : dest_x;
   assign tgt_y  = (out_class == '0) ? inter_y : dest_y;
   assign x_done = (tgt_x == here_x);
   assign y_done = (tgt_y == here_y);

   // ----------------------------------------------------------------------
   // dimension order and port choice
   // ----------------------------------------------------------------------

   always_comb
   begin
      case (dim_order)
         rtr_pkg::DIM_ORDER_DESCENDING: x_first = 1'b0;
         // odd message classes go y first
         rtr_pkg::DIM_ORDER_BY_CLASS:   x_first = ~msg_class[0];
         default:                       x_first = 1'b1;
      endcase
   end

   // first unresolved dimension wins, minus or plus by sign of the offset
   always_comb
   begin
      if (x_done && y_done)
      begin
         port_sel = rtr_pkg::PORT_LOCAL;
      end
      else if (x_first ? !x_done : y_done)
      begin
         port_sel = port_bits'(rtr_pkg::PORT_XM) + port_bits'(tgt_x > here_x);
      end
      else
      begin
         port_sel = port_bits'(rtr_pkg::PORT_YM) + port_bits'(tgt_y > here_y);
      end
   end

   // one-hot port and class request
   always_comb
   begin
      req_next                = '0;
      req_next.op[port_sel]   = 1'b1;
      req_next.orc[out_class] = 1'b1;
      req_next.msg_class      = msg_class;
      req_next.res_class      = res_class;
   end

   // ----------------------------------------------------------------------
   // output register
   // ----------------------------------------------------------------------

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_en <= 1'b0;
      end
      else
      begin
         wr_en <= head_valid;
      end
   end

   // request only loads on a head flit
   always_ff @(posedge clk)
   begin
      if (head_valid)
      begin
         wr_data <= req_next;
      end
   end

endmodule

`default_nettype wire

// File: src/rtr_route_fifo.sv
// circular buffer with combinational head, writes to a full buffer are lost unless a read frees a slot in the same cycle
`default_nettype none
`timescale 1ns/100ps

`include "rtr_cfg.svh"

module rtr_route_fifo #(
   parameter type         payload_t = logic,
   parameter int unsigned depth     = `RTR_FIFO_DEPTH
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     wr_en,
   input  payload_t wr_data,
   input  logic     rd_en,
   output payload_t rd_data,
   output logic     not_empty,
   output logic     drop
);

   localparam int unsigned ptr_bits = (depth > 1) ? $clog2(depth) : 1;
   localparam int unsigned cnt_bits = $clog2(depth + 1);

   payload_t              mem [depth];
   logic [ptr_bits-1:0]   wr_ptr;
   logic [ptr_bits-1:0]   rd_ptr;
   logic [cnt_bits-1:0]   count;
   logic                  full;
   logic                  do_read;
   logic                  do_write;

   // ----------------------------------------------------------------------
   // status and accept logic
   // ----------------------------------------------------------------------

   assign full      = (count == cnt_bits'(depth));
   assign not_empty = (count != '0);
   assign do_read   = rd_en && not_empty;
   // a pop in the same cycle makes room
   assign do_write  = wr_en && (!full || do_read);
   assign drop      = wr_en && !do_write;

   assign rd_data = mem[rd_ptr];

   // ----------------------------------------------------------------------
   // pointers and occupancy
   // ----------------------------------------------------------------------

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         // wrap by compare so any depth works
         if (do_write)
         begin
            wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_read)
         begin
            rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         if (do_write && !do_read)
         begin
            count <= count + 1'b1;
         end
         else if (do_read && !do_write)
         begin
            count <= count - 1'b1;
         end
      end
   end

   // storage
   always_ff @(posedge clk)
   begin
      if (do_write)
      begin
         mem[wr_ptr] <= wr_data;
      end
   end

endmodule

`default_nettype wire

// File: src/rtr_route_filter.sv
// turn and class filter for phased DOR with line connectivity, port_id must be below RTR_NUM_PORTS
`default_nettype none
`timescale 1ns/100ps

`include "rtr_cfg.svh"

module rtr_route_filter #(
   parameter int unsigned port_id = 0
) (
   input  logic                            clk,
   input  logic                            arst_n,
   input  logic [1:0]                      mode_dim_order,
   input  logic                            route_hold,
   input  logic                            not_empty,
   input  rtr_pkg::route_req_t             rd_data,
   output logic                            rd_en,
   output logic                            route_valid,
   output logic [0:`RTR_NUM_PORTS-1]       route_op,
   output logic [0:`RTR_NUM_RES_CLASSES-1] route_orc,
   output logic                            route_error
);

   localparam int unsigned num_net_ports = `RTR_NUM_PORTS - `RTR_NUM_NODES;
   localparam int unsigned nb            = `RTR_NUM_NEIGHBORS_PER_DIM;
   // flits from the local node skip the dimension rule
   localparam logic        net_arrival   = (port_id < num_net_ports);

   rtr_pkg::dim_order_e               dim_order;
   logic                              last_class;
   logic                              asc_active;
   logic                              desc_active;
   logic [0:`RTR_NUM_PORTS-1]         forbid_op;
   logic [0:`RTR_NUM_PORTS-1]         op_masked;
   logic [0:`RTR_NUM_PORTS-1]         error_op;
   logic [0:`RTR_NUM_RES_CLASSES-1]   orc_masked;
   logic                              port_err;

   // pop whenever something waits and the next stage is not holding
   assign rd_en = not_empty && !route_hold;

   assign dim_order  = rtr_pkg::dim_order_e'(mode_dim_order);
   assign last_class = (rd_data.res_class == `RTR_RES_CLASS_BITS'(`RTR_NUM_RES_CLASSES - 1));

   // active order for this message class, reserved acts as ascending
   assign asc_active  = (dim_order == rtr_pkg::DIM_ORDER_ASCENDING) ||
                        (dim_order == rtr_pkg::DIM_ORDER_RESERVED) ||
                        ((dim_order == rtr_pkg::DIM_ORDER_BY_CLASS) && !rd_data.msg_class[0]);
   assign desc_active = (dim_order == rtr_pkg::DIM_ORDER_DESCENDING) ||
                        ((dim_order == rtr_pkg::DIM_ORDER_BY_CLASS) && rd_data.msg_class[0]);

   // ----------------------------------------------------------------------
   // port restrictions
   // ----------------------------------------------------------------------

   // in the last class a flit never u-turns and never re-enters a finished dimension
   // a local arrival never ejects on its own port
   always_comb
   begin
      for (int unsigned op = 0; op < `RTR_NUM_PORTS; op++)
      begin
         if (op < num_net_ports)
         begin
            forbid_op[op] = last_class &&
                            ((op == port_id) ||
                             (net_arrival && asc_active && ((op / nb) < (port_id / nb))) ||
                             (net_arrival && desc_active && ((op / nb) > (port_id / nb))));
         end
         else
         begin
            forbid_op[op] = (op == port_id);
         end
      end
   end

   assign op_masked = rd_data.op & ~forbid_op;
   assign error_op  = rd_data.op & forbid_op;

   // masked request or no port at all
   assign port_err = (|error_op) || !(|rd_data.op);

   // ----------------------------------------------------------------------
   // class restriction
   // ----------------------------------------------------------------------

   // each hop stays in its class or moves up by one
   always_comb
   begin
      for (int unsigned orc = 0; orc < `RTR_NUM_RES_CLASSES; orc++)
      begin
         orc_masked[orc] = rd_data.orc[orc] &&
                           ((orc == rd_data.res_class) || (orc == rd_data.res_class + 1));
      end
   end

   // ----------------------------------------------------------------------
   // output registers
   // ----------------------------------------------------------------------

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         route_valid <= 1'b0;
         route_error <= 1'b0;
      end
      else
      begin
         route_valid <= rd_en;
         route_error <= rd_en && port_err;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rd_en)
      begin
         route_op  <= op_masked;
         route_orc <= orc_masked;
      end
   end

endmodule

`default_nettype wire

// File: src/rtr_route_stage.sv
// routing stage of one input port, latency is 3 cycles only when the fifo is empty and route_hold is low
`default_nettype none
`timescale 1ns/100ps

`include "rtr_cfg.svh"

module rtr_route_stage #(
   parameter int unsigned router_x = 0,
   parameter int unsigned router_y = 0,
   parameter int unsigned port_id  = 0
) (
   input  logic                            clk,
   input  logic                            arst_n,
   input  logic [1:0]                      mode_dim_order,
   input  logic                            head_valid,
   input  logic [`RTR_COORD_BITS-1:0]      dest_x,
   input  logic [`RTR_COORD_BITS-1:0]      dest_y,
   input  logic [`RTR_COORD_BITS-1:0]      inter_x,
   input  logic [`RTR_COORD_BITS-1:0]      inter_y,
   input  logic [`RTR_MSG_CLASS_BITS-1:0]  msg_class,
   input  logic [`RTR_RES_CLASS_BITS-1:0]  res_class,
   input  logic                            route_hold,
   output logic                            route_valid,
   output logic [0:`RTR_NUM_PORTS-1]       route_op,
   output logic [0:`RTR_NUM_RES_CLASSES-1] route_orc,
   output logic                            route_error,
   output logic                            fifo_drop
);

   logic                wr_en;
   rtr_pkg::route_req_t wr_data;
   logic                rd_en;
   rtr_pkg::route_req_t rd_data;
   logic                not_empty;

   // ----------------------------------------------------------------------
   // route compute, buffer, filter
   // ----------------------------------------------------------------------

   rtr_route_compute #(
      .router_x (router_x),
      .router_y (router_y)
   ) compute0 (
      .clk            (clk),
      .arst_n         (arst_n),
      .mode_dim_order (mode_dim_order),
      .head_valid     (head_valid),
      .dest_x         (dest_x),
      .dest_y         (dest_y),
      .inter_x        (inter_x),
      .inter_y        (inter_y),
      .msg_class      (msg_class),
      .res_class      (res_class),
      .wr_en          (wr_en),
      .wr_data        (wr_data)
   );

   // drop pulse leaves the stage untouched
   rtr_route_fifo #(
      .payload_t (rtr_pkg::route_req_t),
      .depth     (`RTR_FIFO_DEPTH)
   ) fifo0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .wr_en     (wr_en),
      .wr_data   (wr_data),
      .rd_en     (rd_en),
      .rd_data   (rd_data),
      .not_empty (not_empty),
      .drop      (fifo_drop)
   );

   rtr_route_filter #(
      .port_id (port_id)
   ) filter0 (
      .clk            (clk),
      .arst_n         (arst_n),
      .mode_dim_order (mode_dim_order),
      .route_hold     (route_hold),
      .not_empty      (not_empty),
      .rd_data        (rd_data),
      .rd_en          (rd_en),
      .route_valid    (route_valid),
      .route_op       (route_op),
      .route_orc      (route_orc),
      .route_error    (route_error)
   );

endmodule

`default_nettype wire

// File: test/rtr_route_properties.sv
// checks assume a router bound at the stage top, all properties idle while arst_n is low
`default_nettype none
`timescale 1ns/100ps

`include "rtr_cfg.svh"

module rtr_route_properties (
   input logic                      clk,
   input logic                      arst_n,
   input logic                      head_valid,
   input logic                      route_hold,
   input logic                      not_empty,
   input logic                      route_valid,
   input logic [0:`RTR_NUM_PORTS-1] route_op,
   input logic                      route_error
);

   // ----------------------------------------------------------------------
   // output consistency
   // ----------------------------------------------------------------------

   // error pulse only rides on a valid route
   error_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
      route_error |-> route_valid)
   else $error("route_error high without route_valid");

   // masking may clear the port, never add a second one
   op_onehot0: assert property (@(posedge clk) disable iff (!arst_n)
      route_valid |-> $onehot0(route_op))
   else $error("route_op has more than one port set");

   // ----------------------------------------------------------------------
   // latency
   // ----------------------------------------------------------------------

   // empty fifo, no hold at the pop cycle, so the route shows three edges later
   empty_latency: assert property (@(posedge clk) disable iff (!arst_n)
      (head_valid && !not_empty && !route_hold) ##2 !route_hold |=> route_valid)
   else $error("route_valid missing three cycles after head_valid");

endmodule

bind rtr_route_stage rtr_route_properties props0 (
   .clk         (clk),
   .arst_n      (arst_n),
   .head_valid  (head_valid),
   .route_hold  (route_hold),
   .not_empty   (not_empty),
   .route_valid (route_valid),
   .route_op    (route_op),
   .route_error (route_error)
);

`default_nettype wire

// File: test/rtr_route_stage_tb.sv
// router at 1,1 fed on the x-plus port, trace mode may only change while the stage is empty
`default_nettype none
`timescale 1ns/100ps

`include "rtr_cfg.svh"

module rtr_route_stage_tb;

   localparam int line_fields = 12;
   localparam int max_lines   = 64;
   localparam int drain_limit = 40;
   localparam int fifo_depth  = `RTR_FIFO_DEPTH;
   localparam int op_w        = `RTR_NUM_PORTS;
   localparam int orc_w       = `RTR_NUM_RES_CLASSES;

   logic                            clk;
   logic                            arst_n;
   logic [1:0]                      mode_dim_order;
   logic                            head_valid;
   logic [`RTR_COORD_BITS-1:0]      dest_x;
   logic [`RTR_COORD_BITS-1:0]      dest_y;
   logic [`RTR_COORD_BITS-1:0]      inter_x;
   logic [`RTR_COORD_BITS-1:0]      inter_y;
   logic [`RTR_MSG_CLASS_BITS-1:0]  msg_class;
   logic [`RTR_RES_CLASS_BITS-1:0]  res_class;
   logic                            route_hold;
   logic                            route_valid;
   logic [0:`RTR_NUM_PORTS-1]       route_op;
   logic [0:`RTR_NUM_RES_CLASSES-1] route_orc;
   logic                            route_error;
   logic                            fifo_drop;

   // one byte per trace token, twelve tokens per line
   logic [7:0] trace_mem [0:line_fields*max_lines-1];

   // expected results packed as {op, orc, err}, port 0 and class 0 in the top bits
   logic [op_w+orc_w:0] exp_q [$];
   logic [op_w+orc_w:0] line_result;
   logic [op_w+orc_w:0] pend_result;

   // fifo occupancy model
   int   model_count;
   logic wr_pend;
   logic exp_valid;

   rtr_route_stage #(
      .router_x (1),
      .router_y (1),
      .port_id  (1)
   ) dut0 (
      .clk            (clk),
      .arst_n         (arst_n),
      .mode_dim_order (mode_dim_order),
      .head_valid     (head_valid),
      .dest_x         (dest_x),
      .dest_y         (dest_y),
      .inter_x        (inter_x),
      .inter_y        (inter_y),
      .msg_class      (msg_class),
      .res_class      (res_class),
      .route_hold     (route_hold),
      .route_valid    (route_valid),
      .route_op       (route_op),
      .route_orc      (route_orc),
      .route_error    (route_error),
      .fifo_drop      (fifo_drop)
   );

   always #50 clk = ~clk;

   // ----------------------------------------------------------------------
   // helpers
   // ----------------------------------------------------------------------

   task automatic end_with_failure();
      $display("Something failed");
      $fatal(1, "stopped at first error");
   endtask

   // apply one trace line, expected result kept for the write that follows
   task automatic drive_line(input int line_idx);
      int base;
      base           = line_idx * line_fields;
      route_hold     = trace_mem[base][0];
      head_valid     = trace_mem[base+1][0];
      mode_dim_order = trace_mem[base+2][1:0];
      dest_x         = trace_mem[base+3][`RTR_COORD_BITS-1:0];
      dest_y         = trace_mem[base+4][`RTR_COORD_BITS-1:0];
      inter_x        = trace_mem[base+5][`RTR_COORD_BITS-1:0];
      inter_y        = trace_mem[base+6][`RTR_COORD_BITS-1:0];
      msg_class      = trace_mem[base+7][`RTR_MSG_CLASS_BITS-1:0];
      res_class      = trace_mem[base+8][`RTR_RES_CLASS_BITS-1:0];
      line_result    = {trace_mem[base+9][op_w-1:0], trace_mem[base+10][orc_w-1:0],
                        trace_mem[base+11][0]};
   endtask

   // mode stays where the trace left it
   task automatic drive_idle();
      route_hold = 1'b0;
      head_valid = 1'b0;
   endtask

   // registered outputs, looked at on the falling edge
   task automatic check_route();
      logic [op_w+orc_w:0] exp;
      assert (route_valid == exp_valid)
      else
      begin
         $display("mismatch at %0t: route_valid expected %b got %b",
                  $time, exp_valid, route_valid);
         end_with_failure();
      end
      if (route_valid)
      begin
         assert (exp_q.size() != 0)
         else
         begin
            $display("route_valid at %0t with no accepted head flit left", $time);
            end_with_failure();
         end
         exp = exp_q.pop_front();
         assert (route_op == exp[op_w+orc_w:orc_w+1])
         else
         begin
            $display("mismatch at %0t: route_op expected %b got %b",
                     $time, exp[op_w+orc_w:orc_w+1], route_op);
            end_with_failure();
         end
         assert (route_orc == exp[orc_w:1])
         else
         begin
            $display("mismatch at %0t: route_orc expected %b got %b",
                     $time, exp[orc_w:1], route_orc);
            end_with_failure();
         end
         assert (route_error == exp[0])
         else
         begin
            $display("mismatch at %0t: route_error expected %b got %b",
                     $time, exp[0], route_error);
            end_with_failure();
         end
      end
   endtask

   // one clock of the fifo model, called once the new inputs have settled
   // pop while not empty and not held, a full write survives only next to a pop
   task automatic step_model();
      logic rd;
      logic wr_ok;
      rd    = (model_count != 0) && !route_hold;
      wr_ok = wr_pend && ((model_count < fifo_depth) || rd);
      assert (fifo_drop == (wr_pend && !wr_ok))
      else
      begin
         $display("mismatch at %0t: fifo_drop expected %b got %b",
                  $time, wr_pend && !wr_ok, fifo_drop);
         end_with_failure();
      end
      if (wr_ok)
      begin
         exp_q.push_back(pend_result);
      end
      model_count = model_count + (wr_ok ? 1 : 0) - (rd ? 1 : 0);
      exp_valid   = rd;
      // producer registers the head flit, the write comes a cycle later
      wr_pend     = head_valid;
      pend_result = line_result;
   endtask

   // ----------------------------------------------------------------------
   // stimulus
   // ----------------------------------------------------------------------

   initial
   begin
      int idx;
      int waited;
      clk            = 1'b0;
      arst_n         = 1'b0;
      mode_dim_order = 2'd0;
      head_valid     = 1'b0;
      dest_x         = '0;
      dest_y         = '0;
      inter_x        = '0;
      inter_y        = '0;
      msg_class      = '0;
      res_class      = '0;
      route_hold     = 1'b0;
      line_result    = '0;
      pend_result    = '0;
      model_count    = 0;
      wr_pend        = 1'b0;
      exp_valid      = 1'b0;
      $readmemh("test/rtr_route_trace.txt", trace_mem);
      if ($isunknown(trace_mem[0]))
      begin
         $display("trace file could not be read");
         end_with_failure();
      end

      repeat (4) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      // one trace line per cycle up to the ff marker
      // lines past the end of the file read as unknown
      idx = 0;
      while (trace_mem[idx*line_fields] !== 8'hff)
      begin
         if ((idx == max_lines) || $isunknown(trace_mem[idx*line_fields]))
         begin
            $display("trace has no end marker within %0d lines", max_lines);
            end_with_failure();
         end
         @(negedge clk);
         check_route();
         drive_line(idx);
         #1;
         step_model();
         idx++;
      end

      // let every accepted flit come out
      waited = 0;
      while ((exp_q.size() != 0) || (model_count != 0) || wr_pend || exp_valid)
      begin
         if (waited == drain_limit)
         begin
            $display("drain timed out with %0d routes still expected", exp_q.size());
            end_with_failure();
         end
         @(negedge clk);
         check_route();
         drive_idle();
         #1;
         step_model();
         waited++;
      end

      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: test/rtr_route_trace.txt
// hold valid mode dest_x dest_y inter_x inter_y msg_class res_class exp_op exp_orc exp_err
// exp_op has port 0 in bit 4, exp_orc has class 0 in bit 1, a line starting ff ends the trace
0 1 0 0 0 3 1 0 0 08 2 0
0 1 0 1 3 0 0 0 1 02 1 0
0 1 0 0 2 0 0 0 1 10 1 0
0 1 0 1 1 0 0 0 1 01 1 0
0 1 0 1 0 1 1 0 0 04 1 0
0 1 0 3 2 0 0 0 1 00 1 1
0 0 0 0 0 0 0 0 0 00 0 0
0 0 0 0 0 0 0 0 0 00 0 0
0 1 1 0 0 2 3 0 0 02 2 0
0 1 1 0 1 0 0 0 1 10 1 0
0 1 1 1 3 0 0 0 1 00 1 1
0 0 1 0 0 0 0 0 0 00 0 0
0 0 1 0 0 0 0 0 0 00 0 0
0 1 2 0 0 2 0 1 0 04 2 0
0 1 2 0 0 2 0 0 0 08 2 0
0 0 2 0 0 0 0 0 0 00 0 0
0 0 2 0 0 0 0 0 0 00 0 0
1 1 0 0 3 0 0 0 1 10 1 0
1 1 0 1 3 0 0 0 1 02 1 0
1 1 0 0 0 3 0 0 0 08 2 0
1 1 0 1 0 0 0 0 1 04 1 0
1 1 0 1 1 0 0 0 1 01 1 0
1 1 0 2 2 1 1 0 0 08 1 0
0 0 0 0 0 0 0 0 0 00 0 0
ff 0 0 0 0 0 0 0 0 00 0 0
